// ==== logic/bus_pkg.sv ====
/*
 * Bus-wide widths and data types for address, data and byte enables
 */

package bus_pkg;

  // Bus widths
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned BeWidth   = DataWidth / 8;

  // Byte address of a transfer
  typedef logic [AddrWidth-1:0] addr_t;

  // Read or write data word
  typedef logic [DataWidth-1:0] data_t;

  // One enable per data byte
  typedef logic [BeWidth-1:0] be_t;

endpackage : bus_pkg

// ==== logic/addr_map_pkg.sv ====
/*
 * Address map: target indices, region bases and sizes,
 * and the rdata word returned for unmapped accesses
 */

package addr_map_pkg;

  // Index of a target on the crossbar
  typedef logic [1:0] target_idx_t;

  // Real targets behind the crossbar, error responder not counted
  localparam int unsigned NumTargets = 2;

  localparam target_idx_t Ram0Idx  = 2'd0;
  localparam target_idx_t Ram1Idx  = 2'd1;
  localparam target_idx_t ErrorIdx = 2'd2;

  // Region bases, each region is RegionBytes long
  localparam bus_pkg::addr_t Ram0Base = 32'h0000_0000;
  localparam bus_pkg::addr_t Ram1Base = 32'h0000_1000;

  localparam int unsigned RegionBytes = 4096;

  // Read data for anything outside both regions
  localparam bus_pkg::data_t ErrorData = 32'hBADA_CCE5;

endpackage : addr_map_pkg

// ==== logic/obi_if.sv ====
/*
 * One OBI link with manager and target modports
 */

`timescale 1ns/1ns

interface obi_if;
  import bus_pkg::*;

  // Request side, driven by the manager
  logic  req;
  addr_t addr;
  logic  we;
  be_t   be;
  data_t wdata;

  // Response side, driven by the target
  logic  gnt;
  logic  rvalid;
  data_t rdata;

  modport manager (
    output req, addr, we, be, wdata,
    input  gnt, rvalid, rdata
  );

  modport target (
    input  req, addr, we, be, wdata,
    output gnt, rvalid, rdata
  );

endinterface : obi_if

// ==== logic/addr_decoder.sv ====
/*
 * Address decoder for one manager port, unmapped addresses go to the error index
 */

`timescale 1ns/1ns

module addr_decoder (
  input  bus_pkg::addr_t           addr_i,
  output addr_map_pkg::target_idx_t idx_o
);
  import bus_pkg::*;
  import addr_map_pkg::*;

  logic in_ram0;
  logic in_ram1;

  // Offset compare, wraps for addresses below the base
  assign in_ram0 = (addr_i - Ram0Base) < addr_t'(RegionBytes);
  assign in_ram1 = (addr_i - Ram1Base) < addr_t'(RegionBytes);

  always_comb begin
    if (in_ram0) begin
      idx_o = Ram0Idx;
    end else if (in_ram1) begin
      idx_o = Ram1Idx;
    end else begin
      idx_o = ErrorIdx;
    end
  end

endmodule : addr_decoder

// ==== logic/target_arbiter.sv ====
/*
 * Round-robin arbiter for one target with a last-winner pointer
 */

`timescale 1ns/1ns

module target_arbiter #(
  parameter int unsigned NumManagers = 2
) (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  logic [NumManagers-1:0] req_i,
  output logic [NumManagers-1:0] grant_o
);

  localparam int unsigned IdxWidth = (NumManagers > 1) ? $clog2(NumManagers) : 1;

  typedef logic [IdxWidth-1:0] mgr_idx_t;

  mgr_idx_t last_q;
  mgr_idx_t win;

  // Search starts one past the last winner and wraps around
  always_comb begin
    int unsigned cand;
    logic        found;

    grant_o = '0;
    win     = last_q;
    found   = 1'b0;
    for (int unsigned k = 1; k <= NumManagers; k++) begin
      cand = (int'(last_q) + k) % NumManagers;
      if (!found && req_i[cand]) begin
        found         = 1'b1;
        grant_o[cand] = 1'b1;
        win           = mgr_idx_t'(cand);
      end
    end
  end

  // Pointer moves only when somebody wins
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      last_q <= '0;
    end else if (|req_i) begin
      last_q <= win;
    end
  end

endmodule : target_arbiter

// ==== logic/bus_xbar.sv ====
/*
 * Crossbar with per-manager decoders, per-target arbiters,
 * response steering and the error responder for unmapped accesses
 */

`timescale 1ns/1ns

module bus_xbar #(
  parameter int unsigned NumManagers = 2
) (
  input  logic                             clk_i,
  input  logic                             arst_n_i,

  input  logic           [NumManagers-1:0] mgr_req_i,
  input  bus_pkg::addr_t [NumManagers-1:0] mgr_addr_i,
  input  logic           [NumManagers-1:0] mgr_we_i,
  input  bus_pkg::be_t   [NumManagers-1:0] mgr_be_i,
  input  bus_pkg::data_t [NumManagers-1:0] mgr_wdata_i,
  output logic           [NumManagers-1:0] mgr_gnt_o,
  output logic           [NumManagers-1:0] mgr_rvalid_o,
  output bus_pkg::data_t [NumManagers-1:0] mgr_rdata_o,

  obi_if.manager tgt [addr_map_pkg::NumTargets]
);
  import bus_pkg::*;
  import addr_map_pkg::*;

  // Decoded target per manager
  target_idx_t [NumManagers-1:0] mgr_idx;

  // Requests split per target and the arbiters' choices
  logic [NumManagers-1:0] arb_req [NumTargets];
  logic [NumManagers-1:0] arb_gnt [NumTargets];
  logic                   tgt_gnt [NumTargets];

  // Response sources, last slot is the error responder
  logic  rsp_rvalid [NumTargets+1];
  data_t rsp_rdata  [NumTargets+1];

  logic [NumManagers-1:0] err_gnt;

  // Per-manager response state
  logic        [NumManagers-1:0] rsp_pending_q;
  target_idx_t [NumManagers-1:0] rsp_idx_q;
  logic        [NumManagers-1:0] err_rd_q;

  for (genvar m = 0; m < NumManagers; m++) begin : gen_dec
    addr_decoder addr_decoder_i (
      .addr_i(mgr_addr_i[m]),
      .idx_o (mgr_idx[m])
    );

    // Error responder is always ready
    assign err_gnt[m] = mgr_req_i[m] && (mgr_idx[m] == ErrorIdx);
  end

  for (genvar t = 0; t < NumTargets; t++) begin : gen_tgt
    addr_t fwd_addr;
    logic  fwd_we;
    be_t   fwd_be;
    data_t fwd_wdata;

    always_comb begin
      for (int unsigned m = 0; m < NumManagers; m++) begin
        arb_req[t][m] = mgr_req_i[m] && (mgr_idx[m] == target_idx_t'(t));
      end
    end

    target_arbiter #(
      .NumManagers(NumManagers)
    ) target_arbiter_i (
      .clk_i   (clk_i),
      .arst_n_i(arst_n_i),
      .req_i   (arb_req[t]),
      .grant_o (arb_gnt[t])
    );

    // One-hot select of the winner's request fields
    always_comb begin
      fwd_addr  = '0;
      fwd_we    = 1'b0;
      fwd_be    = '0;
      fwd_wdata = '0;
      for (int unsigned m = 0; m < NumManagers; m++) begin
        if (arb_gnt[t][m]) begin
          fwd_addr  = mgr_addr_i[m];
          fwd_we    = mgr_we_i[m];
          fwd_be    = mgr_be_i[m];
          fwd_wdata = mgr_wdata_i[m];
        end
      end
    end

    assign tgt[t].req   = |arb_gnt[t];
    assign tgt[t].addr  = fwd_addr;
    assign tgt[t].we    = fwd_we;
    assign tgt[t].be    = fwd_be;
    assign tgt[t].wdata = fwd_wdata;

    assign tgt_gnt[t]    = tgt[t].gnt;
    assign rsp_rvalid[t] = tgt[t].rvalid;
    assign rsp_rdata[t]  = tgt[t].rdata;
  end

  // Error slot answers every cycle, rdata comes from err_rd_q
  assign rsp_rvalid[ErrorIdx] = 1'b1;
  assign rsp_rdata[ErrorIdx]  = '0;

  always_comb begin
    for (int unsigned m = 0; m < NumManagers; m++) begin
      mgr_gnt_o[m] = err_gnt[m];
      for (int unsigned t = 0; t < NumTargets; t++) begin
        mgr_gnt_o[m] = mgr_gnt_o[m] | (arb_gnt[t][m] & tgt_gnt[t]);
      end
    end
  end

  // Remember where each granted transfer went
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rsp_pending_q <= '0;
      rsp_idx_q     <= '0;
      err_rd_q      <= '0;
    end else begin
      rsp_pending_q <= mgr_gnt_o;
      err_rd_q      <= err_gnt & ~mgr_we_i;
      for (int unsigned m = 0; m < NumManagers; m++) begin
        if (mgr_gnt_o[m]) begin
          rsp_idx_q[m] <= mgr_idx[m];
        end
      end
    end
  end

  // Steer responses back one cycle after the grant
  always_comb begin
    for (int unsigned m = 0; m < NumManagers; m++) begin
      mgr_rvalid_o[m] = rsp_pending_q[m] & rsp_rvalid[rsp_idx_q[m]];
      mgr_rdata_o[m]  = err_rd_q[m] ? ErrorData : rsp_rdata[rsp_idx_q[m]];
    end
  end

endmodule : bus_xbar

// ==== logic/sram_target.sv ====
/*
 * SRAM target with byte enables and one-cycle read latency
 */

`timescale 1ns/1ns

module sram_target (
  input  logic  clk_i,
  input  logic  arst_n_i,
  obi_if.target bus
);
  import bus_pkg::*;
  import addr_map_pkg::*;

  localparam int unsigned Depth     = RegionBytes / 4;
  localparam int unsigned WordWidth = $clog2(Depth);

  typedef logic [WordWidth-1:0] word_addr_t;

  data_t      mem [Depth];
  word_addr_t word_addr;
  logic       rvalid_q;
  data_t      rdata_q;

  // Word offset inside the region
  assign word_addr = bus.addr[WordWidth+1:2];

  // Always ready
  assign bus.gnt    = bus.req;
  assign bus.rvalid = rvalid_q;
  assign bus.rdata  = rdata_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= bus.req;
    end
  end

  always_ff @(posedge clk_i) begin
    if (bus.req) begin
      if (bus.we) begin
        rdata_q <= '0;
        for (int unsigned b = 0; b < BeWidth; b++) begin
          if (bus.be[b]) begin
            mem[word_addr][8*b +: 8] <= bus.wdata[8*b +: 8];
          end
        end
      end else begin
        rdata_q <= mem[word_addr];
      end
    end
  end

endmodule : sram_target

// ==== logic/system_bus.sv ====
/*
 * System bus top level: manager ports, crossbar and two SRAM targets
 */

`timescale 1ns/1ns

module system_bus #(
  parameter int unsigned NumManagers = 2
) (
  input  logic                             clk_i,
  input  logic                             arst_n_i,

  // Manager request side
  input  logic           [NumManagers-1:0] req_i,
  input  bus_pkg::addr_t [NumManagers-1:0] addr_i,
  input  logic           [NumManagers-1:0] we_i,
  input  bus_pkg::be_t   [NumManagers-1:0] be_i,
  input  bus_pkg::data_t [NumManagers-1:0] wdata_i,

  // Manager response side
  output logic           [NumManagers-1:0] gnt_o,
  output logic           [NumManagers-1:0] rvalid_o,
  output bus_pkg::data_t [NumManagers-1:0] rdata_o
);
  import addr_map_pkg::*;

  // One link per SRAM
  obi_if tgt_bus [NumTargets] ();

  bus_xbar #(
    .NumManagers(NumManagers)
  ) bus_xbar_i (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .mgr_req_i   (req_i),
    .mgr_addr_i  (addr_i),
    .mgr_we_i    (we_i),
    .mgr_be_i    (be_i),
    .mgr_wdata_i (wdata_i),
    .mgr_gnt_o   (gnt_o),
    .mgr_rvalid_o(rvalid_o),
    .mgr_rdata_o (rdata_o),
    .tgt         (tgt_bus)
  );

  // RAM0 and RAM1
  for (genvar t = 0; t < NumTargets; t++) begin : gen_ram
    sram_target sram_target_i (
      .clk_i   (clk_i),
      .arst_n_i(arst_n_i),
      .bus     (tgt_bus[t])
    );
  end

endmodule : system_bus

// ==== test/system_bus_assertions.sv ====
/*
 * Protocol assertions on the crossbar, bound into bus_xbar
 */

`timescale 1ns/1ns

module system_bus_assertions #(
  parameter int unsigned NumManagers = 2
) (
  input logic                   clk_i,
  input logic                   arst_n_i,
  input logic [NumManagers-1:0] mgr_req_i,
  input logic [NumManagers-1:0] mgr_gnt_o,
  input logic [NumManagers-1:0] mgr_rvalid_o,
  input logic [NumManagers-1:0] arb_gnt [addr_map_pkg::NumTargets]
);
  import addr_map_pkg::*;

  // Response exactly one cycle after the grant
  gnt_then_rvalid: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    mgr_rvalid_o == $past(mgr_gnt_o))
    else $error("rvalid does not follow gnt by one cycle");

  gnt_needs_req: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (mgr_gnt_o & ~mgr_req_i) == '0)
    else $error("gnt without req");

  for (genvar t = 0; t < NumTargets; t++) begin : gen_onehot
    arb_onehot: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      $onehot0(arb_gnt[t]))
      else $error("arbiter grant is not one-hot");
  end

  // Quiet in reset and in the first cycle out of it
  rvalid_reset: assert property (@(posedge clk_i)
    (!arst_n_i || $past(arst_n_i) == 1'b0) |-> mgr_rvalid_o == '0)
    else $error("rvalid high after reset");

endmodule : system_bus_assertions

bind bus_xbar system_bus_assertions #(
  .NumManagers(NumManagers)
) system_bus_assertions_i (
  .clk_i       (clk_i),
  .arst_n_i    (arst_n_i),
  .mgr_req_i   (mgr_req_i),
  .mgr_gnt_o   (mgr_gnt_o),
  .mgr_rvalid_o(mgr_rvalid_o),
  .arb_gnt     (arb_gnt)
);

// ==== test/tb_system_bus.sv ====
/*
 * Testbench for system_bus with table-driven transfers, a reference memory model,
 * round-robin grant prediction and an LFSR-driven random test
 */

`timescale 1ns/1ns

module tb_system_bus;
  import bus_pkg::*;
  import addr_map_pkg::*;

  localparam int unsigned NumMgr     = 2;
  localparam int unsigned NumRandom  = 200;
  localparam logic [31:0] Seed       = 32'had69d47f;
  localparam addr_t       UnmappedLo = 32'h0000_2000;

  typedef struct {
    int unsigned grp;
    int unsigned mgr;
    logic        we;
    addr_t       addr;
    be_t         be;
    data_t       wdata;
    data_t       exp;
  } row_t;

  logic                clk;
  logic                arst_n;
  logic   [NumMgr-1:0] req;
  addr_t  [NumMgr-1:0] addr;
  logic   [NumMgr-1:0] we;
  be_t    [NumMgr-1:0] be;
  data_t  [NumMgr-1:0] wdata;
  logic   [NumMgr-1:0] gnt;
  logic   [NumMgr-1:0] rvalid;
  data_t  [NumMgr-1:0] rdata;

  row_t        rows [$];
  data_t       model_mem [addr_t];
  int unsigned rr_ptr [NumTargets];
  logic [31:0] lfsr;

  // Table addresses in the order they are granted
  addr_t       exp_seq [$];

  // Transfers of the group being issued
  logic [NumMgr-1:0] pend_valid;
  logic [NumMgr-1:0] pend_we;
  addr_t             pend_addr [NumMgr];
  be_t               pend_be [NumMgr];
  data_t             pend_wdata [NumMgr];
  data_t             pend_exp [NumMgr];
  logic              check_table;

  system_bus #(
    .NumManagers(NumMgr)
  ) system_bus_i (
    .clk_i   (clk),
    .arst_n_i(arst_n),
    .req_i   (req),
    .addr_i  (addr),
    .we_i    (we),
    .be_i    (be),
    .wdata_i (wdata),
    .gnt_o   (gnt),
    .rvalid_o(rvalid),
    .rdata_o (rdata)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic check_data(input string name, input data_t exp, input data_t act);
    if (exp !== act) begin
      stop_run($sformatf("ERROR %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_grant(input string name, input logic [NumMgr-1:0] exp,
                             input logic [NumMgr-1:0] act);
    if (exp !== act) begin
      stop_run($sformatf("ERROR %s grant: expected %b, actual %b", name, exp, act));
    end
  endtask

  task automatic check_addr_seq(input string name, input addr_t exp, input addr_t act);
    if (exp !== act) begin
      stop_run($sformatf("ERROR %s address: expected %h, actual %h", name, exp, act));
    end
  endtask

  // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit taken
  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int unsigned i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v    = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic target_idx_t region_of(input addr_t a);
    if (a >= Ram0Base && a < Ram0Base + addr_t'(RegionBytes)) begin
      return 2'd0;
    end
    if (a >= Ram1Base && a < Ram1Base + addr_t'(RegionBytes)) begin
      return 2'd1;
    end
    return 2'd2;
  endfunction

  // Round-robin grant per RAM from the first requester after the last winner
  function automatic logic [NumMgr-1:0] predict_grant(input logic [NumMgr-1:0] r);
    logic [NumMgr-1:0] g;
    logic              found;
    int unsigned       c;
    g = '0;
    // Unmapped accesses are always granted
    for (int unsigned m = 0; m < NumMgr; m++) begin
      if (r[m] && region_of(addr[m]) == 2'd2) begin
        g[m] = 1'b1;
      end
    end
    for (int unsigned t = 0; t < NumTargets; t++) begin
      found = 1'b0;
      for (int unsigned k = 1; k <= NumMgr; k++) begin
        c = (rr_ptr[t] + k) % NumMgr;
        if (!found && r[c] && region_of(addr[c]) == target_idx_t'(t)) begin
          found = 1'b1;
          g[c]  = 1'b1;
        end
      end
    end
    return g;
  endfunction

  // Applies the transfer to the model at its grant and returns the expected rdata
  function automatic data_t respond(input int unsigned m);
    addr_t key;
    data_t word;
    key = pend_addr[m] & ~addr_t'(3);
    if (region_of(pend_addr[m]) == 2'd2) begin
      return pend_we[m] ? '0 : ErrorData;
    end
    if (pend_we[m]) begin
      word = model_mem.exists(key) ? model_mem[key] : '0;
      for (int unsigned b = 0; b < BeWidth; b++) begin
        if (pend_be[m][b]) begin
          word[8*b +: 8] = pend_wdata[m][8*b +: 8];
        end
      end
      model_mem[key] = word;
      return '0;
    end
    return model_mem[key];
  endfunction

  task automatic run_group(input string name);
    logic [NumMgr-1:0] waiting;
    logic [NumMgr-1:0] gnt_now;
    data_t             exp_rsp [NumMgr];
    addr_t             exp_addr;
    waiting = '0;
    for (int unsigned m = 0; m < NumMgr; m++) begin
      req[m]   = pend_valid[m];
      addr[m]  = pend_valid[m] ? pend_addr[m] : '0;
      we[m]    = pend_we[m];
      be[m]    = pend_be[m];
      wdata[m] = pend_wdata[m];
    end
    while (req != '0 || waiting != '0) begin
      @(negedge clk);
      for (int unsigned m = 0; m < NumMgr; m++) begin
        if (waiting[m]) begin
          if (!rvalid[m]) begin
            stop_run($sformatf("%s: manager %0d got no rvalid after its grant", name, m));
          end
          check_data($sformatf("%s model", name), exp_rsp[m], rdata[m]);
          if (check_table) begin
            check_data($sformatf("%s table", name), pend_exp[m], rdata[m]);
          end
        end else if (rvalid[m]) begin
          stop_run($sformatf("%s: manager %0d got rvalid without a grant", name, m));
        end
      end
      check_grant(name, predict_grant(req), gnt);
      gnt_now = gnt & req;
      for (int unsigned m = 0; m < NumMgr; m++) begin
        if (gnt_now[m]) begin
          if (exp_seq.size() != 0) begin
            exp_addr = exp_seq.pop_front();
            check_addr_seq(name, exp_addr, addr[m]);
          end
          exp_rsp[m] = respond(m);
          if (region_of(addr[m]) != 2'd2) begin
            rr_ptr[region_of(addr[m])] = m;
          end
        end
      end
      waiting = gnt_now;
      @(posedge clk);
      #2;
      req = req & ~gnt_now;
    end
  endtask

  task automatic clear_pending();
    pend_valid = '0;
    pend_we    = '0;
    for (int unsigned m = 0; m < NumMgr; m++) begin
      pend_addr[m]  = '0;
      pend_be[m]    = '0;
      pend_wdata[m] = '0;
      pend_exp[m]   = '0;
    end
  endtask

  task automatic add_row(input int unsigned grp, input int unsigned mgr, input logic w,
                         input addr_t a, input be_t b, input data_t d, input data_t e);
    row_t r;
    r.grp   = grp;
    r.mgr   = mgr;
    r.we    = w;
    r.addr  = a;
    r.be    = b;
    r.wdata = d;
    r.exp   = e;
    rows.push_back(r);
  endtask

  task automatic build_table();
    // grp, mgr, we, addr, be, wdata, expected rdata
    // Rows of one group are listed in the order they are granted
    add_row(0, 0, 1'b1, 32'h0000_0010, 4'hF, 32'h1122_3344, 32'h0);
    add_row(1, 0, 1'b1, 32'h0000_0010, 4'h5, 32'hAABB_CCDD, 32'h0);
    add_row(2, 0, 1'b0, 32'h0000_0010, 4'hF, 32'h0,         32'h11BB_33DD);
    // Same offset in both RAMs
    add_row(3, 0, 1'b1, 32'h0000_0020, 4'hF, 32'h0000_AAAA, 32'h0);
    add_row(4, 1, 1'b1, 32'h0000_1020, 4'hF, 32'h0000_BBBB, 32'h0);
    add_row(5, 0, 1'b0, 32'h0000_0020, 4'hF, 32'h0,         32'h0000_AAAA);
    add_row(6, 1, 1'b0, 32'h0000_1020, 4'hF, 32'h0,         32'h0000_BBBB);
    // Unmapped
    add_row(7, 0, 1'b1, 32'h0000_2000, 4'hF, 32'h1234_5678, 32'h0);
    add_row(8, 1, 1'b0, 32'hFFFF_FFF0, 4'hF, 32'h0,         32'hBADA_CCE5);
    add_row(9, 0, 1'b0, 32'h0000_2000, 4'hF, 32'h0,         32'hBADA_CCE5);
    // Contention on RAM0
    add_row(10, 1, 1'b1, 32'h0000_0044, 4'hF, 32'h0B0B_0B0B, 32'h0);
    add_row(10, 0, 1'b1, 32'h0000_0040, 4'hF, 32'h0A0A_0A0A, 32'h0);
    add_row(11, 1, 1'b0, 32'h0000_0040, 4'hF, 32'h0,         32'h0A0A_0A0A);
    add_row(11, 0, 1'b0, 32'h0000_0044, 4'hF, 32'h0,         32'h0B0B_0B0B);
    add_row(12, 1, 1'b0, 32'h0000_0020, 4'hF, 32'h0,         32'h0000_AAAA);
    add_row(12, 0, 1'b0, 32'h0000_0010, 4'hF, 32'h0,         32'h11BB_33DD);
    // Different targets in one cycle
    add_row(13, 0, 1'b0, 32'h0000_0020, 4'hF, 32'h0,         32'h0000_AAAA);
    add_row(13, 1, 1'b0, 32'h0000_1020, 4'hF, 32'h0,         32'h0000_BBBB);
    add_row(14, 0, 1'b0, 32'h0000_3000, 4'hF, 32'h0,         32'hBADA_CCE5);
    add_row(14, 1, 1'b1, 32'h0000_1000, 4'h3, 32'h5555_7777, 32'h0);
  endtask

  function automatic addr_t random_addr(input logic [31:0] sel, input logic [31:0] off);
    addr_t base;
    case (sel % 3)
      0:       base = Ram0Base;
      1:       base = Ram1Base;
      default: base = UnmappedLo;
    endcase
    return base + addr_t'({off[3:0], 2'b00});
  endfunction

  // Watchdog sized from the table and the random test
  initial begin
    #1;
    #(20 * (40 * rows.size() + 10 * NumRandom + 40 * 16 + 40));
    stop_run("Timeout: the bus stopped answering transfers");
  end

  initial begin
    int unsigned idx;
    int unsigned g;
    int unsigned m;
    lfsr     = Seed;
    arst_n   = 1'b0;
    req      = '0;
    addr     = '0;
    we       = '0;
    be       = '0;
    wdata    = '0;
    rr_ptr[0] = 0;
    rr_ptr[1] = 0;
    check_table = 1'b1;
    clear_pending();
    build_table();
    repeat (16) @(posedge clk);
    #2;
    arst_n = 1'b1;

    idx = 0;
    while (idx < rows.size()) begin
      g = rows[idx].grp;
      clear_pending();
      while (idx < rows.size() && rows[idx].grp == g) begin
        m             = rows[idx].mgr;
        pend_valid[m] = 1'b1;
        pend_we[m]    = rows[idx].we;
        pend_addr[m]  = rows[idx].addr;
        pend_be[m]    = rows[idx].be;
        pend_wdata[m] = rows[idx].wdata;
        pend_exp[m]   = rows[idx].exp;
        exp_seq.push_back(rows[idx].addr);
        idx++;
      end
      run_group($sformatf("table group %0d", g));
    end

    // Fill the first 16 words of each RAM so random reads hit known data
    check_table = 1'b0;
    for (int unsigned w = 0; w < 16; w++) begin
      clear_pending();
      pend_valid = 2'b11;
      pend_we    = 2'b11;
      pend_addr[0] = Ram0Base + addr_t'(4 * w);
      pend_addr[1] = Ram1Base + addr_t'(4 * w);
      pend_be[0] = 4'hF;
      pend_be[1] = 4'hF;
      pend_wdata[0] = rand_bits(32);
      pend_wdata[1] = rand_bits(32);
      run_group($sformatf("preload %0d", w));
    end

    for (int unsigned n = 0; n < NumRandom / NumMgr; n++) begin
      clear_pending();
      pend_valid = 2'b11;
      for (int unsigned k = 0; k < NumMgr; k++) begin
        pend_addr[k]  = random_addr(rand_bits(2), rand_bits(4));
        pend_we[k]    = rand_bits(1) != 0;
        pend_be[k]    = be_t'(rand_bits(4));
        pend_wdata[k] = rand_bits(32);
      end
      run_group($sformatf("random %0d", n));
    end

    $display("All tests passed");
    $finish;
  end

endmodule : tb_system_bus

// ==== src.f ====
logic/bus_pkg.sv
logic/addr_map_pkg.sv
logic/obi_if.sv
logic/addr_decoder.sv
logic/target_arbiter.sv
logic/bus_xbar.sv
logic/sram_target.sv
logic/system_bus.sv
test/system_bus_assertions.sv
test/tb_system_bus.sv

// ==== Makefile ====
SIM := obj_dir/Vtb_system_bus

.PHONY: run clean

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "All tests passed" sim.log

$(SIM): src.f $(wildcard logic/*.sv) $(wildcard test/*.sv)
	verilator --binary --timing --assert --top-module tb_system_bus -f src.f

clean:
	rm -rf obj_dir sim.log
